// ==== verilog/if_ctrl_pkg.sv ====
// Control-side definitions for the instruction fetch stage.
// Holds the next-PC and exception-target selectors, the exception cause
// and the fixed entry addresses used by the PC selection logic.

package if_ctrl_pkg;

  //////////////////////////////////////////////////
  // selectors
  //////////////////////////////////////////////////

  // source of the next fetch address on a pc set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of trap target when PC_EXC is selected
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // trap cause as seen by the fetch stage
  typedef struct packed {
    logic       irq_int;
    logic       irq_ext;
    logic [4:0] lower_cause;
  } exc_cause_t;

  //////////////////////////////////////////////////
  // fixed addresses and vector rules
  //////////////////////////////////////////////////

  // debug module entry points
  localparam logic [31:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [31:0] DM_EXC_ADDR  = 32'h1A11_0808;

  // every internal interrupt shares this vector slot
  localparam logic [4:0] NMI_IRQ_VEC = 5'd31;

  // mtvec base is aligned to 256 bytes
  localparam int unsigned MTVEC_ALIGN_W = 8;

  // uncompressed only, so the PC always steps by one word
  localparam int unsigned INSTR_BYTES = 4;

endpackage

// ==== verilog/if_bus_pkg.sv ====
// Data-side definitions for the instruction fetch stage.
// Describes the req/gnt/rvalid instruction bus, the prefetch FIFO entry
// and the registered instruction handed to the decode stage.

package if_bus_pkg;

  // address and data width
  localparam int unsigned XLEN = 32;

  // prefetch FIFO size, which also bounds the requests in flight
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // fetch unit to memory
  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
  } instr_req_t;

  // memory to fetch unit
  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    logic            err;
  } instr_rsp_t;

  // one returned word with the address it was fetched from
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] addr;
    logic            err;
  } fetch_entry_t;

  // instruction held in the IF-ID register
  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] pc;
    logic            fetch_err;
  } id_instr_t;

endpackage

// ==== verilog/if_pc_select.sv ====
// Next fetch address selection for the fetch stage.
// Builds the trap target from mtvec, the cause and the debug entry points,
// then picks the address the prefetch buffer jumps to on a pc set.

`timescale 1ns/1ns

module if_pc_select (
  input  logic                          pc_set_i,
  input  if_ctrl_pkg::pc_sel_e          pc_mux_i,
  input  if_ctrl_pkg::exc_pc_sel_e      exc_pc_mux_i,
  input  if_ctrl_pkg::exc_cause_t       exc_cause_i,
  input  logic [if_bus_pkg::XLEN-1:0]   boot_addr_i,
  input  logic [if_bus_pkg::XLEN-1:0]   branch_target_i,
  input  logic [if_bus_pkg::XLEN-1:0]   csr_mepc_i,
  input  logic [if_bus_pkg::XLEN-1:0]   csr_depc_i,
  input  logic [if_bus_pkg::XLEN-1:0]   csr_mtvec_i,
  output logic [if_bus_pkg::XLEN-1:0]   fetch_addr_o,
  output logic                          csr_mtvec_init_o
);

  import if_bus_pkg::*;
  import if_ctrl_pkg::*;

  logic [XLEN-1:0] mtvec_base;
  logic [XLEN-1:0] exc_pc;
  logic [4:0]      irq_vec;

  // trap table base, low bits forced to zero
  assign mtvec_base = {csr_mtvec_i[XLEN-1:MTVEC_ALIGN_W], {MTVEC_ALIGN_W{1'b0}}};

  // internal interrupts are steered to the NMI slot
  assign irq_vec = exc_cause_i.irq_int ? NMI_IRQ_VEC : exc_cause_i.lower_cause;

  //////////////////////////////////////////////////
  // trap target
  //////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // one word per vector slot
      EXC_PC_IRQ:     exc_pc = mtvec_base + XLEN'({irq_vec, 2'b00});
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  //////////////////////////////////////////////////
  // next fetch address
  //////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_o = boot_addr_i;
      PC_JUMP: fetch_addr_o = branch_target_i;
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap handler
      PC_ERET: fetch_addr_o = csr_mepc_i;
      // return from debug mode
      PC_DRET: fetch_addr_o = csr_depc_i;
      default: fetch_addr_o = boot_addr_i;
    endcase
  end

  // CSR file loads mtvec from the boot address on the first pc set
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== verilog/if_prefetch_buffer.sv ====
// Word prefetcher for the fetch stage on the req/gnt/rvalid bus.
// Keeps at most FIFO_DEPTH words in flight or buffered, and drops the
// responses of requests that were overtaken by a branch.

`timescale 1ns/1ns

module if_prefetch_buffer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic                          branch_i,
  input  logic [if_bus_pkg::XLEN-1:0]   branch_addr_i,
  input  if_bus_pkg::instr_rsp_t        instr_rsp_i,
  input  logic                          fetch_ready_i,
  output if_bus_pkg::instr_req_t        instr_req_o,
  output logic                          fetch_valid_o,
  output if_bus_pkg::fetch_entry_t      fetch_entry_o,
  output logic                          busy_o
);

  import if_bus_pkg::*;

  // request side
  logic [XLEN-1:0]       fetch_addr_q, fetch_addr_d;
  logic [XLEN-1:0]       branch_addr_q;
  logic [XLEN-1:0]       branch_tgt;
  logic                  req_hold_q, req_hold_d;
  logic                  stale_hold_q, stale_hold_d;
  logic                  room;
  logic                  gnt;

  // response side
  logic [FIFO_CNT_W-1:0] out_cnt_q, out_cnt_d;
  logic [FIFO_CNT_W-1:0] discard_cnt_q, discard_cnt_d;
  logic [XLEN-1:0]       rsp_addr_q, rsp_addr_d;
  logic                  rvalid;
  logic                  store;

  // FIFO
  fetch_entry_t          fifo_q [FIFO_DEPTH];
  fetch_entry_t          fifo_d [FIFO_DEPTH];
  fetch_entry_t          rsp_entry;
  logic [FIFO_CNT_W-1:0] fifo_cnt_q, fifo_cnt_d;
  logic [FIFO_CNT_W-1:0] wr_idx;
  logic                  pop;

  //////////////////////////////////////////////////
  // request issue
  //////////////////////////////////////////////////

  // targets are always word aligned
  assign branch_tgt = {branch_addr_i[XLEN-1:2], 2'b00};

  // buffered plus in-flight words must leave space for one more
  assign room = (FIFO_CNT_W'(fifo_cnt_q + out_cnt_q)) < FIFO_CNT_W'(FIFO_DEPTH);

  // a presented request stays up until granted, new ones wait one cycle after a branch
  assign instr_req_o.req  = req_hold_q | (req_i & room & ~branch_i);
  assign instr_req_o.addr = fetch_addr_q;

  assign gnt        = instr_req_o.req & instr_rsp_i.gnt;
  assign req_hold_d = instr_req_o.req & ~instr_rsp_i.gnt;

  // a held request that a branch overtook is fetched and thrown away
  assign stale_hold_d = req_hold_d & (stale_hold_q | branch_i);

  // on a branch behind a held request the old address stays on the bus,
  // the target waits in branch_addr_q
  always_comb begin
    fetch_addr_d = fetch_addr_q;
    if (branch_i && !req_hold_d) begin
      fetch_addr_d = branch_tgt;
    end else if (gnt && stale_hold_q) begin
      fetch_addr_d = branch_addr_q;
    end else if (gnt) begin
      // next word
      fetch_addr_d = {fetch_addr_q[XLEN-1:2] + (XLEN-2)'(1), 2'b00};
    end
  end

  //////////////////////////////////////////////////
  // outstanding and discard tracking
  //////////////////////////////////////////////////

  assign rvalid = instr_rsp_i.rvalid;

  assign out_cnt_d = out_cnt_q + FIFO_CNT_W'(gnt) - FIFO_CNT_W'(rvalid);

  always_comb begin
    discard_cnt_d = discard_cnt_q;
    if (rvalid && (discard_cnt_q != '0)) begin
      discard_cnt_d = discard_cnt_q - FIFO_CNT_W'(1);
    end
    if (branch_i) begin
      // everything still in flight after this cycle belongs to the old stream
      discard_cnt_d = out_cnt_d;
    end else if (gnt && stale_hold_q) begin
      discard_cnt_d = discard_cnt_d + FIFO_CNT_W'(1);
    end
  end

  // keep only responses of the current stream
  assign store = rvalid & ~branch_i & (discard_cnt_q == '0);

  // address of the next kept response
  always_comb begin
    rsp_addr_d = rsp_addr_q;
    if (branch_i) begin
      rsp_addr_d = branch_tgt;
    end else if (store) begin
      rsp_addr_d = {rsp_addr_q[XLEN-1:2] + (XLEN-2)'(1), 2'b00};
    end
  end

  assign rsp_entry.rdata = instr_rsp_i.rdata;
  assign rsp_entry.addr  = rsp_addr_q;
  assign rsp_entry.err   = instr_rsp_i.err;

  //////////////////////////////////////////////////
  // FIFO, head at index 0
  //////////////////////////////////////////////////

  assign fetch_valid_o = (fifo_cnt_q != '0);
  assign fetch_entry_o = fifo_q[0];

  // the squashed handoff of a branch cycle does not pop, the flush clears it
  assign pop    = fetch_valid_o & fetch_ready_i & ~branch_i;
  assign wr_idx = fifo_cnt_q - FIFO_CNT_W'(pop);

  always_comb begin
    fifo_d = fifo_q;
    if (pop) begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++) begin
        fifo_d[i] = fifo_q[i+1];
      end
    end
    if (store) begin
      fifo_d[wr_idx[$clog2(FIFO_DEPTH)-1:0]] = rsp_entry;
    end
  end

  assign fifo_cnt_d = branch_i ? '0 : (wr_idx + FIFO_CNT_W'(store));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q  <= '0;
      rsp_addr_q    <= '0;
      req_hold_q    <= 1'b0;
      stale_hold_q  <= 1'b0;
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
      fifo_cnt_q    <= '0;
    end else begin
      fetch_addr_q  <= fetch_addr_d;
      rsp_addr_q    <= rsp_addr_d;
      req_hold_q    <= req_hold_d;
      stale_hold_q  <= stale_hold_d;
      out_cnt_q     <= out_cnt_d;
      discard_cnt_q <= discard_cnt_d;
      fifo_cnt_q    <= fifo_cnt_d;
    end
  end

  // data storage
  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      branch_addr_q <= branch_tgt;
    end
    if (pop || store) begin
      fifo_q <= fifo_d;
    end
  end

  assign busy_o = instr_req_o.req | (out_cnt_q != '0);

endmodule

// ==== verilog/if_id_pipe.sv ====
// IF-ID pipeline register of the fetch stage.
// Captures each handed-off word with its PC and bus error, and keeps the
// valid and new flags the decode stage uses to track its instruction.

`timescale 1ns/1ns

module if_id_pipe (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_valid_i,
  input  if_bus_pkg::fetch_entry_t  fetch_entry_i,
  input  logic                      id_in_ready_i,
  input  logic                      pc_set_i,
  input  logic                      instr_valid_clear_i,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output if_bus_pkg::id_instr_t     id_instr_o,
  output logic                      handoff_o
);

  import if_bus_pkg::*;

  logic      instr_valid_q, instr_valid_d;
  logic      instr_new_q;
  logic      handoff;
  id_instr_t id_instr_q;

  //////////////////////////////////////////////////
  // handoff and flags
  //////////////////////////////////////////////////

  // ID takes a word whenever it is ready, registers freeze otherwise
  assign handoff = fetch_valid_i & id_in_ready_i;

  // a pc set in the same cycle squashes the word being written
  // valid then holds until ID retires or flushes it
  assign instr_valid_d = (handoff & ~pc_set_i) |
                         (instr_valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_q <= 1'b0;
      instr_new_q   <= 1'b0;
    end else begin
      instr_valid_q <= instr_valid_d;
      // pulses for one cycle after each write
      instr_new_q   <= handoff;
    end
  end

  //////////////////////////////////////////////////
  // instruction registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (handoff) begin
      id_instr_q.rdata     <= fetch_entry_i.rdata;
      id_instr_q.pc        <= fetch_entry_i.addr;
      id_instr_q.fetch_err <= fetch_entry_i.err;
    end
  end

  assign instr_valid_id_o = instr_valid_q;
  assign instr_new_id_o   = instr_new_q;
  assign id_instr_o       = id_instr_q;

  // write enable, also used by the PC sequence check
  assign handoff_o = handoff;

endmodule

// ==== verilog/if_pc_check.sv ====
// Control-flow consistency check for the fetch stage.
// While fetching sequentially, each word entering ID must sit one word
// after the PC already in ID; otherwise an alert is raised.

`timescale 1ns/1ns

module if_pc_check (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          handoff_i,
  input  logic                          pc_set_i,
  input  if_bus_pkg::fetch_entry_t      fetch_entry_i,
  input  logic [if_bus_pkg::XLEN-1:0]   id_pc_i,
  output logic                          pc_mismatch_alert_o
);

  import if_bus_pkg::*;
  import if_ctrl_pkg::*;

  logic            seq_q, seq_d;
  logic [XLEN-1:0] pc_expected;

  // no check after reset, any pc set, or a faulting fetch
  assign seq_d = (seq_q | handoff_i) & ~pc_set_i & ~(handoff_i & fetch_entry_i.err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_expected = id_pc_i + XLEN'(INSTR_BYTES);

  assign pc_mismatch_alert_o = seq_q & handoff_i & (fetch_entry_i.addr != pc_expected);

endmodule

// ==== verilog/if_stage.sv ====
// Top level of the instruction fetch stage.
// Connects PC selection, the prefetch buffer, the IF-ID register and the
// PC sequence check; pc_set_i redirects fetch and squashes the current word.

`timescale 1ns/1ns

module if_stage (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_i,
  input  logic [if_bus_pkg::XLEN-1:0]   boot_addr_i,

  // instruction bus
  output if_bus_pkg::instr_req_t        instr_req_o,
  input  if_bus_pkg::instr_rsp_t        instr_rsp_i,

  // control from the core
  input  logic                          pc_set_i,
  input  if_ctrl_pkg::pc_sel_e          pc_mux_i,
  input  if_ctrl_pkg::exc_pc_sel_e      exc_pc_mux_i,
  input  if_ctrl_pkg::exc_cause_t       exc_cause_i,
  input  logic [if_bus_pkg::XLEN-1:0]   branch_target_i,
  input  logic [if_bus_pkg::XLEN-1:0]   csr_mepc_i,
  input  logic [if_bus_pkg::XLEN-1:0]   csr_depc_i,
  input  logic [if_bus_pkg::XLEN-1:0]   csr_mtvec_i,
  output logic                          csr_mtvec_init_o,

  // decode stage
  input  logic                          id_in_ready_i,
  input  logic                          instr_valid_clear_i,
  output logic                          instr_valid_id_o,
  output logic                          instr_new_id_o,
  output if_bus_pkg::id_instr_t         id_instr_o,
  output logic [if_bus_pkg::XLEN-1:0]   pc_if_o,

  // status
  output logic                          pc_mismatch_alert_o,
  output logic                          if_busy_o
);

  import if_bus_pkg::*;

  logic [XLEN-1:0] fetch_addr;
  logic            fetch_valid;
  fetch_entry_t    fetch_entry;
  logic            handoff;

  //////////////////////////////////////////////////
  // next PC
  //////////////////////////////////////////////////

  if_pc_select pc_select_inst (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_o     (fetch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  //////////////////////////////////////////////////
  // fetch and hand off
  //////////////////////////////////////////////////

  // ready comes straight from ID, no stall sources inside IF
  if_prefetch_buffer prefetch_buffer_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (pc_set_i),
    .branch_addr_i (fetch_addr),
    .instr_rsp_i   (instr_rsp_i),
    .fetch_ready_i (id_in_ready_i),
    .instr_req_o   (instr_req_o),
    .fetch_valid_o (fetch_valid),
    .fetch_entry_o (fetch_entry),
    .busy_o        (if_busy_o)
  );

  if_id_pipe id_pipe_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_entry_i       (fetch_entry),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_instr_o          (id_instr_o),
    .handoff_o           (handoff)
  );

  // compares the incoming word against the PC held in ID
  if_pc_check pc_check_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .handoff_i           (handoff),
    .pc_set_i            (pc_set_i),
    .fetch_entry_i       (fetch_entry),
    .id_pc_i             (id_instr_o.pc),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  assign pc_if_o = fetch_entry.addr;

endmodule

// ==== dv/instr_mem_model.sv ====
// Instruction memory model for the fetch stage testbench.
// Grants requests and returns in-order responses after random delays;
// each word is its address XOR a key, and one address answers with an error.

`timescale 1ns/1ns

module instr_mem_model (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  if_bus_pkg::instr_req_t        req_i,
  input  logic [if_bus_pkg::XLEN-1:0]   err_addr_i,
  input  logic [if_bus_pkg::XLEN-1:0]   key_i,
  output if_bus_pkg::instr_rsp_t        rsp_o
);

  import if_bus_pkg::*;

  integer          seed = 65;
  logic            gnt_en_q;
  logic            rvalid_q;
  logic [XLEN-1:0] rdata_q;
  logic            err_q;

  // addresses granted but not yet answered, oldest first
  logic [XLEN-1:0] pend_q[$];

  //////////////////////////////////////////////////
  // grant and response timing
  //////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    logic [XLEN-1:0] addr;
    if (!rst_ni) begin
      gnt_en_q <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      err_q    <= 1'b0;
      pend_q.delete();
    end else begin
      // grant is offered about three cycles in four
      gnt_en_q <= (($random(seed) & 3) != 0);
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      // answer only requests granted in earlier cycles
      if ((pend_q.size() > 0) && (($random(seed) & 1) != 0)) begin
        addr = pend_q.pop_front();
        rvalid_q <= 1'b1;
        rdata_q  <= addr ^ key_i;
        err_q    <= (addr == err_addr_i);
      end
      if (req_i.req && gnt_en_q) begin
        pend_q.push_back(req_i.addr);
      end
    end
  end

  assign rsp_o.gnt    = req_i.req & gnt_en_q;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign rsp_o.err    = err_q;

endmodule

// ==== dv/tb_if_stage.sv ====
// Testbench for the fetch stage top level.
// Redirects fetch through every PC source and trap kind, applies random
// back-pressure and a bus error, and checks the words that reach ID.

`timescale 1ns/1ns

module tb_if_stage;

  import if_bus_pkg::*;
  import if_ctrl_pkg::*;

  localparam int          CLK_PERIOD  = 100;
  localparam int          TEST_CYC    = 400;
  localparam int          N_TESTS     = 11;
  localparam int          MARGIN      = 2;
  localparam logic [31:0] BOOT_ADDR   = 32'h0000_1000;
  localparam logic [31:0] ERR_ADDR    = 32'h0000_6010;
  localparam logic [31:0] DATA_KEY    = 32'hA5C3_0F69;
  localparam logic [31:0] MTVEC       = 32'h8000_0123;

  logic clk_i, rst_ni, req_i, pc_set_i, id_in_ready_i, instr_valid_clear_i;
  pc_sel_e         pc_mux_i;
  exc_pc_sel_e     exc_pc_mux_i;
  exc_cause_t      exc_cause_i;
  logic [XLEN-1:0] branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  instr_req_t      instr_req;
  instr_rsp_t      instr_rsp;
  logic            instr_valid_id, instr_new_id, csr_mtvec_init;
  logic            pc_mismatch_alert, if_busy;
  id_instr_t       id_instr;
  logic [XLEN-1:0] pc_if;

  // scoreboard state
  int        err_cnt = 0;
  int        chk_cnt = 0;
  int        err_seen = 0;
  int        test_cnt = 0;
  int        bus_out = 0;
  integer    seed = 65;
  logic      bp_en = 1'b0;
  logic [31:0] exp_pc, next_target;
  logic      last_ready;
  id_instr_t last_id;
  logic [XLEN-1:0] last_pc_if;

  if_stage if_stage_inst (
    .clk_i, .rst_ni, .req_i, .boot_addr_i(BOOT_ADDR),
    .instr_req_o(instr_req), .instr_rsp_i(instr_rsp),
    .pc_set_i, .pc_mux_i, .exc_pc_mux_i, .exc_cause_i, .branch_target_i,
    .csr_mepc_i, .csr_depc_i, .csr_mtvec_i, .csr_mtvec_init_o(csr_mtvec_init),
    .id_in_ready_i, .instr_valid_clear_i,
    .instr_valid_id_o(instr_valid_id), .instr_new_id_o(instr_new_id),
    .id_instr_o(id_instr), .pc_if_o(pc_if),
    .pc_mismatch_alert_o(pc_mismatch_alert), .if_busy_o(if_busy)
  );

  instr_mem_model mem_inst (
    .clk_i, .rst_ni, .req_i(instr_req), .err_addr_i(ERR_ADDR),
    .key_i(DATA_KEY), .rsp_o(instr_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // trap target from the architectural rules
  function automatic logic [31:0] trap_addr(exc_pc_sel_e kind, exc_cause_t cause);
    logic [31:0] base;
    base = MTVEC & 32'hFFFF_FF00;
    case (kind)
      EXC_PC_IRQ:     return base + 4 * (cause.irq_int ? 31 : 32'(cause.lower_cause));
      EXC_PC_DBD:     return DM_HALT_ADDR;
      EXC_PC_DBG_EXC: return DM_EXC_ADDR;
      default:        return base;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // checks at the rising edge
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      // all status outputs idle while in reset
      assert ({instr_req.req, instr_valid_id, instr_new_id, csr_mtvec_init,
               pc_mismatch_alert, if_busy} === '0) else begin
        $display("FAIL %0t: output not low during reset", $time);
        err_cnt++;
      end
      bus_out = 0;
    end else begin
      assert (!pc_mismatch_alert) else begin
        $display("FAIL %0t: PC mismatch alert raised", $time);
        err_cnt++;
      end
      // mtvec is initialized by the boot redirect only
      assert (csr_mtvec_init === (pc_set_i && (pc_mux_i == PC_BOOT))) else begin
        $display("FAIL %0t: mtvec init %b with pc set %b", $time, csr_mtvec_init,
                 pc_set_i);
        err_cnt++;
      end
      // ID registers freeze while decode is not ready
      assert (last_ready || (id_instr === last_id)) else begin
        $display("FAIL %0t: ID instruction changed under stall", $time);
        err_cnt++;
      end
      // busy while a request is on the bus or a word is still owed
      assert (if_busy === (instr_req.req || (bus_out != 0))) else begin
        $display("FAIL %0t: busy %b with %0d outstanding", $time, if_busy, bus_out);
        err_cnt++;
      end
      assert (bus_out <= int'(FIFO_DEPTH)) else begin
        $display("FAIL %0t: %0d requests outstanding", $time, bus_out);
        err_cnt++;
      end
      if (instr_valid_id && instr_new_id) begin
        chk_cnt++;
        if (id_instr.fetch_err) begin
          err_seen++;
        end
        assert (id_instr.pc == exp_pc) else begin
          $display("FAIL %0t: pc %h, expected %h", $time, id_instr.pc, exp_pc);
          err_cnt++;
        end
        // pc_if_o showed the word in its handoff cycle
        assert (last_pc_if == exp_pc) else begin
          $display("FAIL %0t: pc_if %h, expected %h", $time, last_pc_if, exp_pc);
          err_cnt++;
        end
        assert (id_instr.rdata == (exp_pc ^ DATA_KEY)) else begin
          $display("FAIL %0t: rdata %h at pc %h", $time, id_instr.rdata, exp_pc);
          err_cnt++;
        end
        assert (id_instr.fetch_err == (exp_pc == ERR_ADDR)) else begin
          $display("FAIL %0t: fetch_err %b at pc %h", $time, id_instr.fetch_err, exp_pc);
          err_cnt++;
        end
        exp_pc = exp_pc + 4;
      end
      // new stream starts on the word aligned target
      if (pc_set_i) begin
        exp_pc = next_target & 32'hFFFF_FFFC;
      end
      if (instr_req.req && instr_rsp.gnt) begin
        bus_out++;
      end
      if (instr_rsp.rvalid) begin
        bus_out--;
      end
    end
    last_ready = id_in_ready_i;
    last_id    = id_instr;
    last_pc_if = pc_if;
  end

  // random decode stalls
  always @(negedge clk_i) begin
    id_in_ready_i = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // one pc set, then wait for n checked words in the new stream
  task automatic redirect(input string name, input pc_sel_e mux, input exc_pc_sel_e kind,
                          input exc_cause_t cause, input logic [31:0] target, input int n);
    int start_chk;
    int start_err;
    @(negedge clk_i);
    pc_set_i     = 1'b1;
    pc_mux_i     = mux;
    exc_pc_mux_i = kind;
    exc_cause_i  = cause;
    next_target  = target;
    @(negedge clk_i);
    pc_set_i  = 1'b0;
    start_chk = chk_cnt;
    start_err = err_cnt;
    while (chk_cnt < start_chk + n) begin
      @(negedge clk_i);
    end
    test_cnt++;
    $display("test %s: %0d words checked, %0d errors", name, chk_cnt - start_chk,
             err_cnt - start_err);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    exc_cause_t none;
    exc_cause_t ext5;
    exc_cause_t intr;
    int         err_before;
    none = '{irq_int: 1'b0, irq_ext: 1'b0, lower_cause: 5'd0};
    ext5 = '{irq_int: 1'b0, irq_ext: 1'b1, lower_cause: 5'd5};
    intr = '{irq_int: 1'b1, irq_ext: 1'b0, lower_cause: 5'd3};
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    exc_cause_i = none;
    branch_target_i = 32'h0000_2002;
    csr_mepc_i = 32'h0000_3006;
    csr_depc_i = 32'h0000_4001;
    csr_mtvec_i = MTVEC;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b1;
    exp_pc = '0;
    next_target = '0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    req_i  = 1'b1;
    redirect("boot", PC_BOOT, EXC_PC_EXC, none, BOOT_ADDR, 12);
    redirect("jump", PC_JUMP, EXC_PC_EXC, none, branch_target_i, 8);
    // short runs branch while requests are still in flight
    redirect("eret", PC_ERET, EXC_PC_EXC, none, csr_mepc_i, 2);
    redirect("dret", PC_DRET, EXC_PC_EXC, none, csr_depc_i, 6);
    redirect("exception", PC_EXC, EXC_PC_EXC, none, trap_addr(EXC_PC_EXC, none), 4);
    redirect("ext irq", PC_EXC, EXC_PC_IRQ, ext5, trap_addr(EXC_PC_IRQ, ext5), 4);
    redirect("int irq", PC_EXC, EXC_PC_IRQ, intr, trap_addr(EXC_PC_IRQ, intr), 4);
    redirect("debug halt", PC_EXC, EXC_PC_DBD, none, trap_addr(EXC_PC_DBD, none), 4);
    redirect("debug exc", PC_EXC, EXC_PC_DBG_EXC, none, trap_addr(EXC_PC_DBG_EXC, none), 4);
    bp_en = 1'b1;
    redirect("back-pressure", PC_JUMP, EXC_PC_EXC, none, branch_target_i, 20);
    bp_en = 1'b0;
    err_before = err_seen;
    branch_target_i = ERR_ADDR - 8;
    redirect("bus error", PC_JUMP, EXC_PC_EXC, none, branch_target_i, 6);
    assert (err_seen == err_before + 1) else begin
      $display("FAIL %0t: %0d faulting words seen", $time, err_seen - err_before);
      err_cnt++;
    end
    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // run length bounded by the total test length
  initial begin
    #(N_TESTS * TEST_CYC * MARGIN * CLK_PERIOD);
    $display("watchdog expired, tests did not complete in time");
    $display("Errors found");
    $finish;
  end

endmodule

// ==== all.f ====
verilog/if_ctrl_pkg.sv
verilog/if_bus_pkg.sv
verilog/if_pc_select.sv
verilog/if_prefetch_buffer.sv
verilog/if_id_pipe.sv
verilog/if_pc_check.sv
verilog/if_stage.sv
dv/instr_mem_model.sv
dv/tb_if_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the fetch stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_if_stage -o sim_if_stage

./obj_dir/sim_if_stage | tee sim.log

if grep -q "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
